// ==== hw/rv_alu.sv ====
`default_nettype none

module rv_alu
(
    input  rv_pkg::alu_op_e i_op,
    input  rv_pkg::word_t   i_a,
    input  rv_pkg::word_t   i_b,
    output rv_pkg::word_t   o_result,
    output logic            o_cond
);

logic w_lt;
logic w_ltu;

assign w_lt  = ($signed(i_a) < $signed(i_b));
assign w_ltu = (i_a < i_b);

always_comb
begin
    o_result = '0;
    o_cond   = 1'b0;

    case (i_op)
        rv_pkg::alu_add:  o_result = i_a + i_b;
        rv_pkg::alu_sub:  o_result = i_a - i_b;
        rv_pkg::alu_slt:  o_result = {31'b0, w_lt};
        rv_pkg::alu_sltu: o_result = {31'b0, w_ltu};
        rv_pkg::alu_xor:  o_result = i_a ^ i_b;
        rv_pkg::alu_or:   o_result = i_a | i_b;
        rv_pkg::alu_and:  o_result = i_a & i_b;

        // branch compares
        rv_pkg::alu_eq:   o_cond = (i_a == i_b);
        rv_pkg::alu_ne:   o_cond = (i_a != i_b);
        rv_pkg::alu_lt:   o_cond = w_lt;
        rv_pkg::alu_ge:   o_cond = !w_lt;
        rv_pkg::alu_ltu:  o_cond = w_ltu;
        rv_pkg::alu_geu:  o_cond = !w_ltu;
        default:
        begin
            o_result = '0;
            o_cond   = 1'b0;
        end
    endcase
end

endmodule

`default_nettype wire

// ==== hw/rv_control.sv ====
`default_nettype none

module rv_control
#(
    parameter rv_pkg::word_t p_reset_pc = '0
)
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_enable,

    rv_dec_if.consumer    dec,
    output rv_pkg::word_t o_inst,

    input  rv_pkg::word_t i_rs1_data,
    input  rv_pkg::word_t i_rs2_data,
    output rv_pkg::word_t o_alu_b,
    input  rv_pkg::word_t i_alu_result,
    input  logic          i_alu_cond,

    output logic          o_rd_wr_en,
    output rv_pkg::word_t o_rd_data,

    output logic          o_mem_write_en,
    output rv_pkg::word_t o_mem_addr,
    output rv_pkg::word_t o_mem_data,
    input  rv_pkg::word_t i_mem_data,

    output logic          o_halted
);

typedef enum logic [2:0]
{
    st_fetch,
    st_fetch_wait,
    st_decode,
    st_execute,
    st_load_wait,
    st_load_write,
    st_halt
} state_e;

state_e        r_state;
rv_pkg::word_t r_pc;
rv_pkg::word_t r_inst_buf;

rv_pkg::word_t w_pc_plus4;
rv_pkg::word_t w_pc_imm;
logic          w_writes_rd;

assign o_inst   = r_inst_buf;
assign o_halted = (r_state == st_halt);

assign w_pc_plus4 = r_pc + 32'd4;
// branch, jal and auipc all add the immediate to pc
assign w_pc_imm   = r_pc + dec.imm;

assign o_alu_b = dec.use_imm ? dec.imm : i_rs2_data;

assign w_writes_rd = (dec.inst_class == rv_pkg::cls_lui)
                  || (dec.inst_class == rv_pkg::cls_auipc)
                  || (dec.inst_class == rv_pkg::cls_jal)
                  || (dec.inst_class == rv_pkg::cls_jalr)
                  || (dec.inst_class == rv_pkg::cls_op_imm)
                  || (dec.inst_class == rv_pkg::cls_op);

assign o_rd_wr_en = i_enable
                 && (((r_state == st_execute) && w_writes_rd) || (r_state == st_load_write));

always_comb
begin
    if (r_state == st_load_write)
        o_rd_data = i_mem_data;
    else
    begin
        case (dec.inst_class)
            rv_pkg::cls_lui:   o_rd_data = dec.imm;
            rv_pkg::cls_auipc: o_rd_data = w_pc_imm;
            rv_pkg::cls_jal,
            rv_pkg::cls_jalr:  o_rd_data = w_pc_plus4;
            default:           o_rd_data = i_alu_result;
        endcase
    end
end

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        r_state        <= st_fetch;
        r_pc           <= p_reset_pc;
        o_mem_write_en <= 1'b0;
        o_mem_addr     <= p_reset_pc;
    end
    else if (i_enable)
    begin
        case (r_state)
            st_fetch:
            begin
                // also ends a store strobe
                o_mem_write_en <= 1'b0;
                o_mem_addr     <= r_pc;
                r_state        <= st_fetch_wait;
            end
            st_fetch_wait:
            begin
                r_state <= st_decode;
            end
            st_decode:
            begin
                r_inst_buf <= i_mem_data;
                r_state    <= st_execute;
            end
            st_execute:
            begin
                r_pc    <= w_pc_plus4;
                r_state <= st_fetch;
                case (dec.inst_class)
                    rv_pkg::cls_jal:
                        r_pc <= w_pc_imm;
                    rv_pkg::cls_jalr:
                        r_pc <= {i_alu_result[31:1], 1'b0};
                    rv_pkg::cls_branch:
                    begin
                        if (i_alu_cond)
                            r_pc <= w_pc_imm;
                    end
                    rv_pkg::cls_load:
                    begin
                        o_mem_addr <= i_alu_result;
                        r_state    <= st_load_wait;
                    end
                    rv_pkg::cls_store:
                    begin
                        o_mem_write_en <= 1'b1;
                        o_mem_addr     <= i_alu_result;
                        o_mem_data     <= i_rs2_data;
                    end
                    rv_pkg::cls_illegal:
                    begin
                        r_pc    <= r_pc;
                        r_state <= st_halt;
                    end
                    default:
                    begin
                    end
                endcase
            end
            st_load_wait:
            begin
                r_state <= st_load_write;
            end
            st_load_write:
            begin
                r_state <= st_fetch;
            end
            default:
            begin
                // halted until reset
                r_state <= st_halt;
            end
        endcase
    end
end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

module rv_core
#(
    parameter rv_pkg::word_t p_reset_pc = '0
)
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_enable,

    output logic          o_mem_write_en,
    output rv_pkg::word_t o_mem_addr,
    output rv_pkg::word_t o_mem_data,
    input  rv_pkg::word_t i_mem_data,

    output logic          o_halted
);

rv_pkg::word_t w_inst;
rv_pkg::word_t w_rs1_data;
rv_pkg::word_t w_rs2_data;
rv_pkg::word_t w_alu_b;
rv_pkg::word_t w_alu_result;
logic          w_alu_cond;
logic          w_rd_wr_en;
rv_pkg::word_t w_rd_data;

rv_dec_if dec_bus ();

rv_decode u_decode
(
    .i_inst (w_inst),
    .dec    (dec_bus.producer)
);

rv_regfile u_regfile
(
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (dec_bus.rs1),
    .i_rs2      (dec_bus.rs2),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_wr_en    (w_rd_wr_en),
    .i_rd       (dec_bus.rd),
    .i_rd_data  (w_rd_data)
);

// operand a is always rs1
rv_alu u_alu
(
    .i_op     (dec_bus.alu_op),
    .i_a      (w_rs1_data),
    .i_b      (w_alu_b),
    .o_result (w_alu_result),
    .o_cond   (w_alu_cond)
);

rv_control #(.p_reset_pc(p_reset_pc)) u_control
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .dec            (dec_bus.consumer),
    .o_inst         (w_inst),
    .i_rs1_data     (w_rs1_data),
    .i_rs2_data     (w_rs2_data),
    .o_alu_b        (w_alu_b),
    .i_alu_result   (w_alu_result),
    .i_alu_cond     (w_alu_cond),
    .o_rd_wr_en     (w_rd_wr_en),
    .o_rd_data      (w_rd_data),
    .o_mem_write_en (o_mem_write_en),
    .o_mem_addr     (o_mem_addr),
    .o_mem_data     (o_mem_data),
    .i_mem_data     (i_mem_data),
    .o_halted       (o_halted)
);

endmodule

`default_nettype wire

// ==== hw/rv_dec_if.sv ====
`default_nettype none

interface rv_dec_if;

    rv_pkg::inst_class_e inst_class;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    // sign extended, already shifted for b, u and j formats
    rv_pkg::word_t       imm;
    logic                use_imm;

    modport producer
    (
        output inst_class, alu_op, rd, rs1, rs2, imm, use_imm
    );

    modport consumer
    (
        input inst_class, alu_op, rd, rs1, rs2, imm, use_imm
    );

endinterface

`default_nettype wire

// ==== hw/rv_decode.sv ====
`default_nettype none

module rv_decode
(
    input  rv_pkg::word_t i_inst,
    rv_dec_if.producer    dec
);

logic [6:0] w_opcode;
logic [2:0] w_funct3;
logic [6:0] w_funct7;

rv_pkg::word_t w_imm_i;
rv_pkg::word_t w_imm_s;
rv_pkg::word_t w_imm_b;
rv_pkg::word_t w_imm_u;
rv_pkg::word_t w_imm_j;

rv_pkg::alu_op_e w_arith_op;
logic            w_arith_ok;

assign w_opcode = i_inst[6:0];
assign w_funct3 = i_inst[14:12];
assign w_funct7 = i_inst[31:25];

assign w_imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
assign w_imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
assign w_imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
assign w_imm_u = {i_inst[31:12], 12'b0};
assign w_imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

assign dec.rd  = i_inst[11:7];
assign dec.rs1 = i_inst[19:15];
assign dec.rs2 = i_inst[24:20];

// funct3 map shared by op and op_imm, shift slots are rejected
always_comb
begin
    w_arith_ok = 1'b1;
    case (w_funct3)
        3'b000:  w_arith_op = rv_pkg::alu_add;
        3'b010:  w_arith_op = rv_pkg::alu_slt;
        3'b011:  w_arith_op = rv_pkg::alu_sltu;
        3'b100:  w_arith_op = rv_pkg::alu_xor;
        3'b110:  w_arith_op = rv_pkg::alu_or;
        3'b111:  w_arith_op = rv_pkg::alu_and;
        default:
        begin
            w_arith_op = rv_pkg::alu_add;
            w_arith_ok = 1'b0;
        end
    endcase
end

always_comb
begin
    dec.inst_class = rv_pkg::cls_illegal;
    dec.alu_op     = rv_pkg::alu_add;
    dec.imm        = w_imm_i;
    dec.use_imm    = 1'b1;

    case (w_opcode)
        rv_pkg::opc_lui:
        begin
            dec.inst_class = rv_pkg::cls_lui;
            dec.imm        = w_imm_u;
        end
        rv_pkg::opc_auipc:
        begin
            dec.inst_class = rv_pkg::cls_auipc;
            dec.imm        = w_imm_u;
        end
        rv_pkg::opc_jal:
        begin
            dec.inst_class = rv_pkg::cls_jal;
            dec.imm        = w_imm_j;
        end
        rv_pkg::opc_jalr:
        begin
            if (w_funct3 == 3'b000)
                dec.inst_class = rv_pkg::cls_jalr;
        end
        rv_pkg::opc_branch:
        begin
            dec.imm        = w_imm_b;
            dec.use_imm    = 1'b0;
            dec.inst_class = rv_pkg::cls_branch;
            case (w_funct3)
                3'b000:  dec.alu_op = rv_pkg::alu_eq;
                3'b001:  dec.alu_op = rv_pkg::alu_ne;
                3'b100:  dec.alu_op = rv_pkg::alu_lt;
                3'b101:  dec.alu_op = rv_pkg::alu_ge;
                3'b110:  dec.alu_op = rv_pkg::alu_ltu;
                3'b111:  dec.alu_op = rv_pkg::alu_geu;
                default: dec.inst_class = rv_pkg::cls_illegal;
            endcase
        end
        rv_pkg::opc_load:
        begin
            // word accesses only
            if (w_funct3 == 3'b010)
                dec.inst_class = rv_pkg::cls_load;
        end
        rv_pkg::opc_store:
        begin
            dec.imm = w_imm_s;
            if (w_funct3 == 3'b010)
                dec.inst_class = rv_pkg::cls_store;
        end
        rv_pkg::opc_op_imm:
        begin
            dec.alu_op = w_arith_op;
            if (w_arith_ok)
                dec.inst_class = rv_pkg::cls_op_imm;
        end
        rv_pkg::opc_op:
        begin
            dec.use_imm = 1'b0;
            dec.alu_op  = w_arith_op;
            if (w_funct7 == 7'b0000000 && w_arith_ok)
            begin
                dec.inst_class = rv_pkg::cls_op;
            end
            else if (w_funct7 == 7'b0100000 && w_funct3 == 3'b000)
            begin
                dec.inst_class = rv_pkg::cls_op;
                dec.alu_op     = rv_pkg::alu_sub;
            end
        end
        default:
        begin
            dec.inst_class = rv_pkg::cls_illegal;
        end
    endcase
end

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0]
    {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_illegal
    } inst_class_e;

    // the last six only drive the condition flag
    typedef enum logic [3:0]
    {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge,
        alu_ltu,
        alu_geu
    } alu_op_e;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // all zero is never a legal encoding
    localparam word_t inst_halt = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`default_nettype none

module rv_regfile
(
    input  logic             i_clk,
    input  logic             i_rst,

    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    output rv_pkg::word_t    o_rs1_data,
    output rv_pkg::word_t    o_rs2_data,

    input  logic             i_wr_en,
    input  rv_pkg::reg_idx_t i_rd,
    input  rv_pkg::word_t    i_rd_data
);

// x1 to x31, x0 has no storage
rv_pkg::word_t r_regs [1:31];

assign o_rs1_data = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
assign o_rs2_data = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

always_ff @(posedge i_clk)
begin
    // no writes while the core sits in reset
    if (!i_rst && i_wr_en && i_rd != '0)
    begin
        r_regs[i_rd] <= i_rd_data;
    end
end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

// ==== tb.f ====
hw/rv_pkg.sv
hw/rv_dec_if.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_control.sv
hw/rv_core.sv
test/rv_core_assert.sv
test/tb_rv_core.sv

// ==== test/rv_core_assert.sv ====
`default_nettype none

module rv_core_assert
(
    input wire logic i_clk,
    input wire logic i_rst,
    input wire logic i_enable,
    input wire logic o_mem_write_en,
    input wire logic o_halted
);

timeunit 1ns;
timeprecision 1ps;

a_strobe_after_reset: assert property (@(posedge i_clk) i_rst |=> !o_mem_write_en)
    else $error("store strobe high after reset");

// an enabled cycle always ends the strobe
a_strobe_single: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_enable && o_mem_write_en) |=> !o_mem_write_en)
    else $error("store strobe high on two enabled edges");

a_halt_sticky: assert property (@(posedge i_clk) (o_halted && !i_rst) |=> o_halted)
    else $error("o_halted dropped without reset");

endmodule

bind rv_core rv_core_assert u_core_assert
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .o_mem_write_en (o_mem_write_en),
    .o_halted       (o_halted)
);

`default_nettype wire

// ==== test/tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;

timeunit 1ns;
timeprecision 1ps;

localparam int total_insts = 600;
localparam real timeout_ns = total_insts * 6 * 100.0 * 2.0 + 20000.0;

logic          i_clk;
logic          i_rst;
logic          i_enable;
logic          o_mem_write_en;
rv_pkg::word_t o_mem_addr;
rv_pkg::word_t o_mem_data;
rv_pkg::word_t i_mem_data;
logic          o_halted;

rv_pkg::word_t mem [0:1023];
rv_pkg::word_t ref_mem [0:1023];

rv_pkg::word_t prog [$];
rv_pkg::word_t exp_addr [$];
rv_pkg::word_t exp_val [$];
rv_pkg::word_t pre_addr [$];
rv_pkg::word_t pre_val [$];
int            slot;
integer        seed;

rv_core rv_core_i
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .o_mem_write_en (o_mem_write_en),
    .o_mem_addr     (o_mem_addr),
    .o_mem_data     (o_mem_data),
    .i_mem_data     (i_mem_data),
    .o_halted       (o_halted)
);

// combinational read port
assign i_mem_data = mem[o_mem_addr[11:2]];

initial
begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
end

initial
begin
    #(timeout_ns);
    $display("Timeout: the core did not halt in the expected time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
end

task automatic check_word(rv_pkg::word_t got, rv_pkg::word_t expv, string msg);
    if (got !== expv)
    begin
        $display("MISMATCH at %0t: %s got %08h expected %08h", $time, msg, got, expv);
        $display("Simulation FAILED");
        $fatal(1, "word compare failed");
    end
endtask

task automatic check_flag(logic got, logic expv, string msg);
    if (got !== expv)
    begin
        $display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, expv);
        $display("Simulation FAILED");
        $fatal(1, "flag compare failed");
    end
endtask

// instruction encoders
function automatic rv_pkg::word_t enc_i(logic [6:0] opc, logic [2:0] f3,
                                        rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3, rv_pkg::reg_idx_t rd,
                                        rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
endfunction

function automatic rv_pkg::word_t enc_s(rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2,
                                        logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::opc_store};
endfunction

function automatic rv_pkg::word_t enc_b(logic [2:0] f3, rv_pkg::reg_idx_t rs1,
                                        rv_pkg::reg_idx_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::opc_branch};
endfunction

function automatic rv_pkg::word_t enc_u(logic [6:0] opc, rv_pkg::reg_idx_t rd,
                                        logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic rv_pkg::word_t enc_j(rv_pkg::reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::opc_jal};
endfunction

// expected results straight from the rv32i rules
function automatic rv_pkg::word_t arith_expect(logic [2:0] f3, rv_pkg::word_t a,
                                               rv_pkg::word_t b);
    case (f3)
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return a + b;
    endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic emit(rv_pkg::word_t w);
    prog.push_back(w);
endtask

task automatic emit_li(rv_pkg::reg_idx_t rd, rv_pkg::word_t val);
    rv_pkg::word_t hi;
    hi = val + 32'h800;
    emit(enc_u(rv_pkg::opc_lui, rd, hi[31:12]));
    emit(enc_i(rv_pkg::opc_op_imm, 3'b000, rd, rd, val[11:0]));
endtask

// results land at 0x800 upwards, x31 holds the base
task automatic store_result(rv_pkg::reg_idx_t rs, rv_pkg::word_t expv);
    logic [11:0] off;
    off = 12'(slot * 4);
    emit(enc_s(5'd31, rs, off));
    exp_addr.push_back(32'h800 + {20'b0, off});
    exp_val.push_back(expv);
    slot++;
endtask

task automatic start_program();
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    pre_addr.delete();
    pre_val.delete();
    slot = 0;
    emit_li(5'd31, 32'h800);
endtask

task automatic load_memory();
    for (int i = 0; i < 1024; i++)
        mem[i] = 32'h9e37_79b9 * i;
    for (int i = 0; i < prog.size(); i++)
        mem[i] = prog[i];
    for (int i = 0; i < pre_addr.size(); i++)
        mem[pre_addr[i][11:2]] = pre_val[i];
endtask

task automatic apply_reset();
    @(posedge i_clk);
    i_rst    <= 1'b1;
    i_enable <= 1'b1;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    check_flag(o_halted, 1'b0, "o_halted after reset");
    check_flag(o_mem_write_en, 1'b0, "o_mem_write_en after reset");
endtask

// serves stores, optionally pauses, returns once halted
task automatic run_to_halt(bit paused);
    logic          en_prev;
    logic          prev_we;
    rv_pkg::word_t prev_addr;
    bit            done;
    int            pause_left;
    rv_pkg::word_t r;
    en_prev    = 1'b1;
    prev_we    = o_mem_write_en;
    prev_addr  = o_mem_addr;
    done       = 0;
    pause_left = 0;
    while (!done)
    begin
        if (!en_prev)
        begin
            check_word(o_mem_addr, prev_addr, "o_mem_addr moved while paused");
            check_flag(o_mem_write_en, prev_we, "o_mem_write_en moved while paused");
        end
        if (o_mem_write_en)
            mem[o_mem_addr[11:2]] = o_mem_data;
        if (o_halted)
            done = 1;
        prev_addr = o_mem_addr;
        prev_we   = o_mem_write_en;
        en_prev   = i_enable;
        if (!done)
        begin
            @(posedge i_clk);
            if (paused && pause_left == 0)
            begin
                r = $random(seed);
                if (r[2:0] == 3'd0)
                    pause_left = 1 + int'(r[5:4]);
            end
            if (pause_left > 0)
            begin
                i_enable <= 1'b0;
                pause_left--;
            end
            else
                i_enable <= 1'b1;
            @(negedge i_clk);
        end
    end
endtask

task automatic run_and_check(bit paused, string name);
    load_memory();
    apply_reset();
    run_to_halt(paused);
    for (int i = 0; i < exp_addr.size(); i++)
        check_word(mem[exp_addr[i][11:2]], exp_val[i],
                   $sformatf("%s result at %08h", name, exp_addr[i]));
endtask

task automatic test_reset_halt();
    prog.delete();
    pre_addr.delete();
    emit(rv_pkg::inst_halt);
    load_memory();
    apply_reset();
    // fetch, fetch_wait, decode and execute come before the halt state
    for (int i = 0; i < 4; i++)
    begin
        check_flag(o_halted, 1'b0, "o_halted before the illegal word executes");
        check_flag(o_mem_write_en, 1'b0, "o_mem_write_en while running the illegal word");
        @(negedge i_clk);
    end
    check_flag(o_halted, 1'b1, "o_halted on illegal word");
    check_flag(o_mem_write_en, 1'b0, "o_mem_write_en after halt");
endtask

task automatic test_arith();
    logic [2:0]    imm_f3 [6];
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t r;
    rv_pkg::word_t simm;
    rv_pkg::word_t pc;
    imm_f3 = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
    start_program();
    for (int round = 0; round < 2; round++)
    begin
        a = $random(seed);
        b = $random(seed);
        r = $random(seed);
        simm = {{20{r[11]}}, r[11:0]};
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        foreach (imm_f3[k])
        begin
            emit(enc_i(rv_pkg::opc_op_imm, imm_f3[k], 5'd3, 5'd1, r[11:0]));
            store_result(5'd3, arith_expect(imm_f3[k], a, simm));
            emit(enc_r(7'b0, imm_f3[k], 5'd3, 5'd1, 5'd2));
            store_result(5'd3, arith_expect(imm_f3[k], a, b));
        end
        emit(enc_r(7'b0100000, 3'b000, 5'd3, 5'd1, 5'd2));
        store_result(5'd3, a - b);
        emit(enc_u(rv_pkg::opc_lui, 5'd3, r[31:12]));
        store_result(5'd3, {r[31:12], 12'b0});
        pc = 32'(prog.size() * 4);
        emit(enc_u(rv_pkg::opc_auipc, 5'd3, r[31:12]));
        store_result(5'd3, pc + {r[31:12], 12'b0});
    end
    // x0 stays zero
    emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd0, 5'd1, 12'h123));
    store_result(5'd0, 32'h0);
    emit(rv_pkg::inst_halt);
    run_and_check(0, "arith");
    for (int i = 0; i < 1024; i++)
        ref_mem[i] = mem[i];
endtask

// same program again, with random pauses
task automatic test_pause();
    run_and_check(1, "paused arith");
    for (int i = 0; i < 1024; i++)
        check_word(mem[i], ref_mem[i], $sformatf("paused run memory word %0d", i));
endtask

task automatic test_control();
    logic [2:0]    br_f3 [6];
    rv_pkg::word_t va [3];
    rv_pkg::word_t vb [3];
    rv_pkg::word_t pc;
    rv_pkg::word_t tgt;
    br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    va    = '{32'hffff_ffff, 32'h0000_0001, 32'h8000_0000};
    vb    = '{32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    start_program();
    foreach (br_f3[k])
    begin
        for (int p = 0; p < 3; p++)
        begin
            emit_li(5'd1, va[p]);
            emit_li(5'd2, vb[p]);
            emit(enc_b(br_f3[k], 5'd1, 5'd2, 13'd12));
            emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd5, 5'd0, 12'd1));
            emit(enc_j(5'd0, 21'd8));
            emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd5, 5'd0, 12'd2));
            store_result(5'd5, branch_taken(br_f3[k], va[p], vb[p]) ? 32'd2 : 32'd1);
        end
    end
    emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd7, 5'd0, 12'd3));
    pc = 32'(prog.size() * 4);
    emit(enc_j(5'd6, 21'd8));
    emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd7, 5'd0, 12'd9));
    store_result(5'd6, pc + 32'd4);
    store_result(5'd7, 32'd3);
    // target one past an even address, bit 0 must be dropped
    tgt = 32'(prog.size() * 4 + 16);
    emit_li(5'd8, tgt);
    pc = 32'(prog.size() * 4);
    emit(enc_i(rv_pkg::opc_jalr, 3'b000, 5'd9, 5'd8, 12'd1));
    emit(enc_i(rv_pkg::opc_op_imm, 3'b000, 5'd7, 5'd0, 12'd9));
    store_result(5'd9, pc + 32'd4);
    store_result(5'd7, 32'd3);
    emit(rv_pkg::inst_halt);
    run_and_check(0, "control");
endtask

task automatic test_memory();
    rv_pkg::word_t v;
    logic [11:0]   off;
    start_program();
    emit_li(5'd30, 32'h900);
    for (int i = 0; i < 8; i++)
    begin
        v   = $random(seed);
        off = 12'(i * 4);
        pre_addr.push_back(32'h900 + {20'b0, off});
        pre_val.push_back(v);
        emit(enc_i(rv_pkg::opc_load, 3'b010, 5'd10, 5'd30, off));
        store_result(5'd10, v);
    end
    emit(rv_pkg::inst_halt);
    run_and_check(0, "memory copy");
endtask

initial
begin
    i_rst    = 1'b1;
    i_enable = 1'b0;
    seed     = 32'h28a7;
    test_reset_halt();
    test_arith();
    test_pause();
    test_control();
    test_memory();
    $display("Simulation PASSED");
    $finish;
end

endmodule

`default_nettype wire
